// ==== dv/cpu_tb.sv ====
// Testbench with memory models, test programs, reference interpreter, checker and watchdog
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int test_count = 5;
	localparam logic [15:0] err_word = 16'hF000;

	logic        clk;
	logic        rst;
	logic        reset_req;
	logic        load_dmem;
	logic [15:0] imem_addr;
	logic [15:0] imem_data;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic        dmem_we;
	logic        dmem_re;
	logic [15:0] dmem_rdata;
	logic        halted;

	logic [15:0] imem [512];
	logic [15:0] dmem [65536];
	logic [15:0] ref_dmem [65536];
	logic [15:0] exp_addr[$];
	logic [15:0] exp_data[$];
	logic [15:0] exp_load[$];
	logic [15:0] got_addr[$];
	logic [15:0] got_data[$];
	logic [15:0] got_load[$];
	logic [8:0]  load_ptr;
	logic        late_store;
	int          errors;
	int          test_errors;
	int          failed_tests;

	tb_clock i_clock (.clk(clk), .rst(rst), .reset_req(reset_req));

	cpu_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_re    (dmem_re),
		.dmem_rdata (dmem_rdata),
		.halted     (halted)
	);

	// Unused program space reads as ERR
	assign imem_data  = (imem_addr < 16'd512) ? imem[imem_addr[8:0]] : err_word;
	assign dmem_rdata = dmem[dmem_addr];

	function automatic logic [15:0] fill_word(logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	always @(posedge clk) begin
		if (load_dmem) begin
			for (int a = 0; a < 65536; a++)
				dmem[16'(a)] <= fill_word(16'(a));
		end else if (dmem_we)
			dmem[dmem_addr] <= dmem_wdata;
	end

	// Store and load log
	always @(posedge clk) begin
		if (dmem_we === 1'b1) begin
			got_addr.push_back(dmem_addr);
			got_data.push_back(dmem_wdata);
			if (halted === 1'b1)
				late_store = 1'b1;
		end
		if (dmem_re === 1'b1)
			got_load.push_back(dmem_addr);
	end

	function automatic logic [15:0] enc_r(logic [3:0] op, logic [3:0] rd, logic [3:0] rs,
			logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] enc_i(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [7:0] rand8();
		return 8'($urandom());
	endfunction

	task automatic emit(input logic [15:0] word);
		imem[load_ptr] = word;
		load_ptr = load_ptr + 9'd1;
	endtask

	task automatic emit_call(input logic [8:0] target);
		logic [11:0] off;
		off = 12'(target) - 12'(load_ptr) - 12'd1; // Relative to PC + 1
		emit({op_call, off});
	endtask

	task automatic clear_program();
		for (int i = 0; i < 512; i++)
			imem[9'(i)] = err_word;
		load_ptr = 9'd0;
	endtask

	// ISA model, runs the program until ERR and returns the PC the core should hold
	function automatic logic [15:0] run_reference();
		logic [15:0] r [16];
		logic [15:0] pc;
		logic [15:0] npc;
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [15:0] ea;
		logic        z;
		logic        n;
		logic        v;
		logic        take;
		for (int i = 0; i < 65536; i++)
			ref_dmem[16'(i)] = fill_word(16'(i));
		for (int i = 0; i < 16; i++)
			r[4'(i)] = 16'h0000;
		r[15] = 16'h0100;
		pc = 16'h0000;
		z = 1'b0;
		n = 1'b0;
		v = 1'b0;
		for (int step = 0; step < 4000; step++) begin
			w = (pc < 16'd512) ? imem[pc[8:0]] : err_word;
			a = r[w[7:4]];
			b = (w[15:12] == op_inc) ? {{12{w[3]}}, w[3:0]} : r[w[3:0]];
			ea = r[14] + {{8{w[7]}}, w[7:0]};
			npc = pc + 16'd1;
			res = 16'h0000;
			case (w[15:12])
				op_add, op_inc: res = a + b;
				op_sub:  res = a - b;
				op_nand: res = ~(a & b);
				op_xor:  res = a ^ b;
				op_sra:  res = 16'($signed(a) >>> b[3:0]);
				op_srl:  res = a >> b[3:0];
				op_sll:  res = a << b[3:0];
				op_lw: begin
					r[w[11:8]] = ref_dmem[ea];
					exp_load.push_back(ea);
				end
				op_sw: begin
					ref_dmem[ea] = r[w[11:8]];
					exp_addr.push_back(ea);
					exp_data.push_back(r[w[11:8]]);
				end
				op_lhb:  r[w[11:8]][15:8] = w[7:0];
				op_llb:  r[w[11:8]][7:0] = w[7:0];
				op_b: begin
					case (w[11:9])
						cond_eq: take = z;
						cond_ne: take = ~z;
						cond_lt: take = n;
						cond_ge: take = ~n;
						cond_gt: take = ~z & ~n;
						cond_le: take = z | n;
						cond_ov: take = v;
						default: take = 1'b1;
					endcase
					if (take)
						npc = npc + {{7{w[8]}}, w[8:0]};
				end
				op_call: begin
					r[15] = r[15] - 16'd1;
					ref_dmem[r[15]] = npc;
					exp_addr.push_back(r[15]);
					exp_data.push_back(npc);
					npc = npc + {{4{w[11]}}, w[11:0]};
				end
				op_ret: begin
					exp_load.push_back(r[15]);
					npc = ref_dmem[r[15]];
					r[15] = r[15] + 16'd1;
				end
				default: return npc; // ERR still steps the PC once
			endcase
			if (!w[15]) begin
				r[w[11:8]] = res;
				z = (res == 16'h0000);
				n = res[15];
				v = 1'b0;
				if (w[15:12] == op_add || w[15:12] == op_inc)
					v = (a[15] == b[15]) && (res[15] != a[15]);
				else if (w[15:12] == op_sub)
					v = (a[15] != b[15]) && (res[15] != a[15]);
			end
			r[0] = 16'h0000;
			pc = npc;
		end
		return 16'hFFFF;
	endfunction

	task automatic check_value(input string test, input string what,
			input logic [15:0] expected, input logic [15:0] actual);
		if (expected !== actual) begin
			$display("Error %s %s: expected %h actual %h", test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic run_test(input string name);
		logic [15:0] exp_pc;
		logic [15:0] halt_pc;
		exp_addr.delete();
		exp_data.delete();
		exp_load.delete();
		test_errors = 0;
		exp_pc = run_reference();
		@(posedge clk);
		reset_req <= 1'b1;
		load_dmem <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		load_dmem <= 1'b0;
		wait (rst == 1'b1);
		wait (rst == 1'b0);
		got_addr.delete();
		got_data.delete();
		got_load.delete();
		late_store = 1'b0;
		while (halted !== 1'b1)
			@(posedge clk);
		halt_pc = imem_addr;
		repeat (6) @(posedge clk); // Stores past ERR would land here
		if (exp_pc == 16'hFFFF) begin
			$display("%s: the reference program never reached ERR", name);
			test_errors++;
		end
		if (late_store) begin
			$display("%s: the core wrote memory while halted", name);
			test_errors++;
		end
		check_value(name, "store count", 16'(exp_addr.size()), 16'(got_addr.size()));
		for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
			check_value(name, $sformatf("store %0d address", i), exp_addr[i], got_addr[i]);
			check_value(name, $sformatf("store %0d data", i), exp_data[i], got_data[i]);
		end
		check_value(name, "load count", 16'(exp_load.size()), 16'(got_load.size()));
		for (int i = 0; i < exp_load.size() && i < got_load.size(); i++)
			check_value(name, $sformatf("load %0d address", i), exp_load[i], got_load[i]);
		check_value(name, "PC at halt", exp_pc, halt_pc);
		check_value(name, "PC after halt", exp_pc, imem_addr);
		$display("Test %s done: %0d stores, %0d mismatches", name, got_addr.size(), test_errors);
		errors += test_errors;
		if (test_errors != 0)
			failed_tests++;
	endtask

	initial begin
		#(test_count * 300 * 40);
		$display("Watchdog expired before the core halted");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		reset_req <= 1'b0;
		load_dmem <= 1'b1;
		errors = 0;
		failed_tests = 0;
		late_store = 1'b0;
		void'($urandom(32'h37b53d48));

		// All eight ALU operations on random operands
		clear_program();
		emit(enc_i(op_lhb, 4'd14, 8'h02)); // DS = 0x0200
		for (int s = 0; s < 2; s++) begin
			emit(enc_i(op_llb, 4'd1, rand8()));
			emit(enc_i(op_lhb, 4'd1, rand8()));
			emit(enc_i(op_llb, 4'd2, rand8()));
			emit(enc_i(op_lhb, 4'd2, rand8()));
			for (int op = 0; op < 8; op++) begin
				emit(enc_r(4'(op), 4'd3, 4'd1, (4'(op) == op_inc) ? 4'(rand8()) : 4'd2));
				emit(enc_i(op_sw, 4'd3, 8'(s * 8 + op)));
			end
		end
		run_test("alu");

		// Every condition after zero, positive, negative and overflow results
		clear_program();
		emit(enc_i(op_lhb, 4'd14, 8'h03));
		emit(enc_i(op_llb, 4'd1, 8'h01));
		emit(enc_i(op_lhb, 4'd2, 8'h80));
		emit(enc_i(op_llb, 4'd3, 8'hff));
		emit(enc_i(op_lhb, 4'd3, 8'h7f));
		for (int k = 0; k < 32; k++) begin
			case (k / 8)
				0: emit(enc_r(op_xor, 4'd4, 4'd1, 4'd1));
				1: emit(enc_r(op_add, 4'd4, 4'd1, 4'd0));
				2: emit(enc_r(op_add, 4'd4, 4'd2, 4'd0));
				default: emit(enc_r(op_add, 4'd4, 4'd3, 4'd1));
			endcase
			emit({op_b, 3'(k), 9'd2});
			emit(enc_i(op_llb, 4'd5, 8'(2 * k))); // Not taken marker
			emit({op_b, cond_tr, 9'd1});
			emit(enc_i(op_llb, 4'd5, 8'(2 * k + 1)));
			emit(enc_i(op_sw, 4'd5, 8'(k)));
		end
		run_test("branches");

		// Loads and stores around DS, byte merges into loaded words
		clear_program();
		emit(enc_i(op_lhb, 4'd14, 8'h04));
		emit(enc_i(op_llb, 4'd14, 8'h80));
		emit(enc_i(op_lw, 4'd1, 8'h05));
		emit(enc_i(op_sw, 4'd1, 8'hfd));
		emit(enc_i(op_lw, 4'd2, 8'hfd));
		emit(enc_i(op_sw, 4'd2, 8'h7f));
		emit(enc_i(op_llb, 4'd3, rand8()));
		emit(enc_i(op_lhb, 4'd3, rand8()));
		emit(enc_i(op_sw, 4'd3, 8'h80));
		emit(enc_i(op_lw, 4'd4, 8'h80));
		emit(enc_i(op_sw, 4'd4, 8'h10));
		for (int i = 0; i < 4; i++) begin
			emit(enc_i(op_lw, 4'd6, rand8()));
			emit(enc_i((i % 2 == 0) ? op_lhb : op_llb, 4'd6, rand8()));
			emit(enc_i(op_sw, 4'd6, 8'(32 + i)));
		end
		run_test("memory");

		// Three nested calls at 16, 32 and 48
		clear_program();
		emit(enc_i(op_lhb, 4'd14, 8'h02));
		emit_call(9'd16);
		emit(enc_i(op_sw, 4'd1, 8'h00));
		emit(enc_i(op_sw, 4'd15, 8'h01));
		for (int d = 1; d <= 3; d++) begin
			load_ptr = 9'(16 * d);
			emit(enc_r(op_inc, 4'd1, 4'd1, 4'(d)));
			emit(enc_i(op_sw, 4'd15, 8'(2 * d)));
			if (d < 3)
				emit_call(9'(16 * d + 16));
			emit(enc_i(op_sw, 4'd1, 8'(2 * d + 1)));
			emit(enc_i(op_ret, 4'd0, 8'h00));
		end
		run_test("calls");

		// Stores behind ERR must never reach memory
		clear_program();
		emit(enc_i(op_llb, 4'd1, rand8()));
		emit(enc_i(op_sw, 4'd1, 8'h00));
		emit(enc_i(op_err, 4'd0, 8'h00));
		emit(enc_i(op_sw, 4'd1, 8'h01));
		emit(enc_i(op_sw, 4'd1, 8'h02));
		emit(enc_r(op_add, 4'd1, 4'd1, 4'd1));
		run_test("halt");

		$display("Tests run %0d, failed %0d, mismatches %0d", test_count, failed_tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== dv/tb_clock.sv ====
// Clock and reset generator for the testbench
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst,
	input  logic reset_req
);
	int cycles_left;

	initial begin
		clk         = 1'b0;
		rst         <= 1'b1;
		cycles_left <= 3;
	end

	always #20 clk = ~clk; // 40 ns period

	// Reset held for four rising edges after power-up or a request
	always @(posedge clk) begin
		if (reset_req) begin
			rst         <= 1'b1;
			cycles_left <= 3;
		end else if (cycles_left > 0)
			cycles_left <= cycles_left - 1;
		else
			rst <= 1'b0;
	end

endmodule

// ==== files.f ====
hw/cpu_pkg.sv
hw/ctrl_if.sv
hw/control_logic.sv
hw/reg_file.sv
hw/alu.sv
hw/pc_unit.sv
hw/cpu_top.sv
dv/tb_clock.sv
dv/cpu_tb.sv

// ==== hw/alu.sv ====
// Eight-operation ALU with operand select and the Z, N, V flag register
`timescale 1ns/1ps

module alu (
	input  logic            clk,
	input  logic            rst,
	ctrl_if.datapath        ctl,
	input  cpu_pkg::instr_u instr,
	input  logic [15:0]     rd1,
	input  logic [15:0]     rd2,
	output logic [15:0]     result,
	output logic            flag_z,
	output logic            flag_n,
	output logic            flag_v
);
	import cpu_pkg::*;

	logic [15:0] imm_ext;
	logic [15:0] op_b;
	logic [15:0] sum;
	logic [15:0] diff;
	logic        ovf;
	logic        arith_op;
	logic        is_alu_op;

	assign imm_ext = ctl.sign_ext_sel ? {{12{instr.r.rt[3]}}, instr.r.rt}
		: {{8{instr.i.imm8[7]}}, instr.i.imm8};
	assign op_b = ctl.alu_src ? imm_ext : rd2;

	assign sum  = rd1 + op_b;
	assign diff = rd1 - op_b;

	assign arith_op  = (ctl.alu_op == op_add[2:0]) || (ctl.alu_op == op_sub[2:0])
		|| (ctl.alu_op == op_inc[2:0]);
	assign is_alu_op = ~instr.r.opcode[3]; // Flags only move on the ALU group

	always_comb begin
		ovf = 1'b0;
		case (ctl.alu_op)
			op_add[2:0], op_inc[2:0]: begin
				result = sum;
				ovf    = (rd1[15] == op_b[15]) && (sum[15] != rd1[15]);
			end
			op_sub[2:0]: begin
				result = diff;
				ovf    = (rd1[15] != op_b[15]) && (diff[15] != rd1[15]);
			end
			op_nand[2:0]: result = ~(rd1 & op_b);
			op_xor[2:0]:  result = rd1 ^ op_b;
			op_sra[2:0]:  result = 16'($signed(rd1) >>> op_b[3:0]);
			op_srl[2:0]:  result = rd1 >> op_b[3:0];
			default:      result = rd1 << op_b[3:0]; // SLL
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
		end else if (is_alu_op) begin
			flag_z <= (result == 16'h0000);
			flag_n <= result[15];
			flag_v <= ovf & arith_op; // Cleared by logic and shift ops
		end
	end

	a_v_only_arith: assert property (@(posedge clk) disable iff (rst)
		(is_alu_op && instr.r.opcode != op_add && instr.r.opcode != op_sub
			&& instr.r.opcode != op_inc) |=> !flag_v)
		else $error("V set by a logic or shift operation");

endmodule

// ==== hw/control_logic.sv ====
// Opcode decoder driving the control bundle
`timescale 1ns/1ps

module control_logic (
	input logic [3:0] opcode,
	ctrl_if.decoder   ctl
);
	import cpu_pkg::*;

	always_comb begin
		// Everything idle unless the opcode needs it
		ctl.data_reg     = 1'b0;
		ctl.call         = 1'b0;
		ctl.rtrn         = 1'b0;
		ctl.branch       = 1'b0;
		ctl.mem_to_reg   = 1'b0;
		ctl.reg_to_mem   = 1'b0;
		ctl.alu_op       = op_add[2:0];
		ctl.alu_src      = 1'b0;
		ctl.sign_ext_sel = 1'b0;
		ctl.reg_rt_src   = 1'b0;
		ctl.reg_write    = 1'b0;
		ctl.half_spec    = 1'b0;
		ctl.halt         = 1'b0;

		case (opcode)
			op_add, op_sub, op_nand, op_xor, op_sra, op_srl, op_sll: begin
				ctl.alu_op    = opcode[2:0];
				ctl.reg_write = 1'b1;
			end
			op_inc: begin
				ctl.alu_op       = opcode[2:0];
				ctl.alu_src      = 1'b1;
				ctl.sign_ext_sel = 1'b1; // Increment from the rt field
				ctl.reg_write    = 1'b1;
			end
			op_lw: begin
				ctl.data_reg   = 1'b1;
				ctl.mem_to_reg = 1'b1;
				ctl.alu_src    = 1'b1;
				ctl.reg_write  = 1'b1;
			end
			op_sw: begin
				ctl.data_reg   = 1'b1;
				ctl.reg_to_mem = 1'b1;
				ctl.alu_src    = 1'b1;
				ctl.reg_rt_src = 1'b1; // Store data comes from rd
			end
			op_lhb: begin
				ctl.reg_rt_src = 1'b1; // Old rd value for the merge
				ctl.reg_write  = 1'b1;
			end
			op_llb: begin
				ctl.reg_rt_src = 1'b1;
				ctl.reg_write  = 1'b1;
				ctl.half_spec  = 1'b1;
			end
			op_b: begin
				ctl.branch = 1'b1;
			end
			op_call: begin
				ctl.call       = 1'b1;
				ctl.reg_to_mem = 1'b1; // Push return address
				ctl.reg_write  = 1'b1;
			end
			op_ret: begin
				ctl.rtrn       = 1'b1;
				ctl.mem_to_reg = 1'b0;
				ctl.reg_write  = 1'b1;
			end
			op_err: begin
				ctl.halt = 1'b1;
			end
			default: begin
				ctl.halt = 1'b0;
			end
		endcase

		// A known opcode must give a known ALU operation
		if (!$isunknown(opcode))
			assert (!$isunknown(ctl.alu_op))
				else $error("alu_op has unknown bits for opcode %h", opcode);
	end

endmodule

// ==== hw/cpu_pkg.sv ====
// Opcodes, branch conditions, register indices, reset values and the instruction word union
package cpu_pkg;

	// ALU group, low three bits double as the ALU operation
	localparam logic [3:0] op_add  = 4'd0;
	localparam logic [3:0] op_sub  = 4'd1;
	localparam logic [3:0] op_nand = 4'd2;
	localparam logic [3:0] op_xor  = 4'd3;
	localparam logic [3:0] op_inc  = 4'd4;
	localparam logic [3:0] op_sra  = 4'd5;
	localparam logic [3:0] op_srl  = 4'd6;
	localparam logic [3:0] op_sll  = 4'd7;

	// Memory, byte, flow control
	localparam logic [3:0] op_lw   = 4'd8;
	localparam logic [3:0] op_sw   = 4'd9;
	localparam logic [3:0] op_lhb  = 4'd10;
	localparam logic [3:0] op_llb  = 4'd11;
	localparam logic [3:0] op_b    = 4'd12;
	localparam logic [3:0] op_call = 4'd13;
	localparam logic [3:0] op_ret  = 4'd14;
	localparam logic [3:0] op_err  = 4'd15;

	// Branch conditions
	localparam logic [2:0] cond_eq = 3'd0;
	localparam logic [2:0] cond_lt = 3'd1;
	localparam logic [2:0] cond_gt = 3'd2;
	localparam logic [2:0] cond_ov = 3'd3;
	localparam logic [2:0] cond_ne = 3'd4;
	localparam logic [2:0] cond_ge = 3'd5;
	localparam logic [2:0] cond_le = 3'd6;
	localparam logic [2:0] cond_tr = 3'd7;

	localparam logic [3:0] reg_ds = 4'd14; // Data segment base
	localparam logic [3:0] reg_sp = 4'd15; // Stack pointer

	localparam logic [15:0] sp_reset = 16'h0100;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt; // Also the 4-bit immediate of INC
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [7:0] imm8;
		} i;
		struct packed {
			logic [3:0] opcode;
			logic [2:0] cond;
			logic [8:0] offset;
		} b;
	} instr_u;

endpackage

// ==== hw/cpu_top.sv ====
// Single-cycle 16-bit core top level with instruction and data memory ports
`timescale 1ns/1ps

module cpu_top (
	input  logic        clk,
	input  logic        rst,
	output logic [15:0] imem_addr,
	input  logic [15:0] imem_data,
	output logic [15:0] dmem_addr,
	output logic [15:0] dmem_wdata,
	output logic        dmem_we,
	output logic        dmem_re,
	input  logic [15:0] dmem_rdata,
	output logic        halted
);
	import cpu_pkg::*;

	instr_u      instr;
	logic [15:0] pc;
	logic [15:0] rd1;
	logic [15:0] rd2;
	logic [15:0] alu_result;
	logic        flag_z;
	logic        flag_n;
	logic        flag_v;

	ctrl_if ctl ();

	assign instr     = imem_data;
	assign imem_addr = pc;

	control_logic i_control (
		.opcode (instr.r.opcode),
		.ctl    (ctl.decoder)
	);

	reg_file i_reg_file (
		.clk        (clk),
		.rst        (rst),
		.ctl        (ctl.datapath),
		.instr      (instr),
		.alu_result (alu_result),
		.dmem_rdata (dmem_rdata),
		.rd1        (rd1),
		.rd2        (rd2),
		.halted     (halted)
	);

	alu i_alu (
		.clk    (clk),
		.rst    (rst),
		.ctl    (ctl.datapath),
		.instr  (instr),
		.rd1    (rd1),
		.rd2    (rd2),
		.result (alu_result),
		.flag_z (flag_z),
		.flag_n (flag_n),
		.flag_v (flag_v)
	);

	pc_unit i_pc_unit (
		.clk        (clk),
		.rst        (rst),
		.ctl        (ctl.datapath),
		.instr      (instr),
		.flag_z     (flag_z),
		.flag_n     (flag_n),
		.flag_v     (flag_v),
		.dmem_rdata (dmem_rdata),
		.pc         (pc),
		.halted     (halted)
	);

	// Memory address is DS + imm8, or the stack slot on CALL and RET
	assign dmem_addr  = alu_result;
	assign dmem_wdata = ctl.call ? pc + 16'd1 : rd2; // Return address on CALL
	assign dmem_we    = ctl.reg_to_mem & ~rst & ~halted;
	assign dmem_re    = (ctl.mem_to_reg | ctl.rtrn) & ~rst & ~halted;

endmodule

// ==== hw/ctrl_if.sv ====
// Decoded control signal bundle with decoder and datapath views
`timescale 1ns/1ps

interface ctrl_if;
	logic       data_reg;     // Port 1 reads DS
	logic       call;         // Port 1 reads SP - 1, write to SP
	logic       rtrn;         // Port 1 reads SP, write SP + 1
	logic       branch;
	logic       mem_to_reg;   // Load
	logic       reg_to_mem;   // Store
	logic [2:0] alu_op;
	logic       alu_src;      // Second operand is the immediate
	logic       sign_ext_sel; // 1 for 4-bit immediate, 0 for imm8
	logic       reg_rt_src;   // Port 2 reads rd instead of rt
	logic       reg_write;
	logic       half_spec;    // 0 LHB, 1 LLB
	logic       halt;

	modport decoder (output data_reg, call, rtrn, branch, mem_to_reg, reg_to_mem,
		alu_op, alu_src, sign_ext_sel, reg_rt_src, reg_write, half_spec, halt);

	modport datapath (input data_reg, call, rtrn, branch, mem_to_reg, reg_to_mem,
		alu_op, alu_src, sign_ext_sel, reg_rt_src, reg_write, half_spec, halt);

endinterface

// ==== hw/pc_unit.sv ====
// Program counter, branch condition check, call and return targets, halt latch
`timescale 1ns/1ps

module pc_unit (
	input  logic            clk,
	input  logic            rst,
	ctrl_if.datapath        ctl,
	input  cpu_pkg::instr_u instr,
	input  logic            flag_z,
	input  logic            flag_n,
	input  logic            flag_v,
	input  logic [15:0]     dmem_rdata,
	output logic [15:0]     pc,
	output logic            halted
);
	import cpu_pkg::*;

	logic [15:0] pc_inc;
	logic [15:0] br_target;
	logic [15:0] call_target;
	logic [15:0] next_pc;
	logic        taken;

	assign pc_inc      = pc + 16'd1;
	assign br_target   = pc_inc + {{7{instr.b.offset[8]}}, instr.b.offset};
	// CALL offset spans the low 12 bits
	assign call_target = pc_inc + {{4{instr.i.rd[3]}}, instr.i.rd, instr.i.imm8};

	always_comb begin
		case (instr.b.cond)
			cond_eq: taken = flag_z;
			cond_lt: taken = flag_n;
			cond_gt: taken = ~flag_z & ~flag_n;
			cond_ov: taken = flag_v;
			cond_ne: taken = ~flag_z;
			cond_ge: taken = ~flag_n;
			cond_le: taken = flag_z | flag_n;
			default: taken = 1'b1; // TR
		endcase
	end

	always_comb begin
		if (ctl.rtrn)
			next_pc = dmem_rdata; // Popped return address
		else if (ctl.call)
			next_pc = call_target;
		else if (ctl.branch && taken)
			next_pc = br_target;
		else
			next_pc = pc_inc;
	end

	// ERR still advances the PC once, then everything freezes
	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= 16'h0000;
			halted <= 1'b0;
		end else if (!halted) begin
			pc     <= next_pc;
			halted <= ctl.halt;
		end
	end

	a_pc_frozen: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted && $stable(pc))
		else $error("PC moved while halted");

endmodule

// ==== hw/reg_file.sv ====
// Sixteen-entry register file with DS and SP steering and write-back select
`timescale 1ns/1ps

module reg_file (
	input  logic            clk,
	input  logic            rst,
	ctrl_if.datapath        ctl,
	input  cpu_pkg::instr_u instr,
	input  logic [15:0]     alu_result,
	input  logic [15:0]     dmem_rdata,
	output logic [15:0]     rd1,
	output logic [15:0]     rd2,
	input  logic            halted
);
	import cpu_pkg::*;

	logic [15:0] regs [16];
	logic [3:0]  rd_idx1;
	logic [3:0]  rd_idx2;
	logic [3:0]  wr_idx;
	logic [15:0] rd_val1;
	logic [15:0] byte_merge;
	logic [15:0] wr_data;
	logic        stack_op;
	logic        wr_en;

	assign stack_op = ctl.call | ctl.rtrn;

	// Port 1 is DS for memory ops, SP for stack ops
	assign rd_idx1 = ctl.data_reg ? reg_ds : (stack_op ? reg_sp : instr.r.rs);
	// R0 on port 2 during stack ops, so the ALU adds zero
	assign rd_idx2 = stack_op ? 4'd0 : (ctl.reg_rt_src ? instr.r.rd : instr.r.rt);

	assign rd_val1 = (rd_idx1 == 4'd0) ? 16'h0000 : regs[rd_idx1];
	assign rd1     = ctl.call ? rd_val1 - 16'd1 : rd_val1;
	assign rd2     = (rd_idx2 == 4'd0) ? 16'h0000 : regs[rd_idx2];

	// LLB keeps the high byte, LHB the low byte
	assign byte_merge = ctl.half_spec ? {rd2[15:8], instr.i.imm8} : {instr.i.imm8, rd2[7:0]};

	always_comb begin
		if (ctl.mem_to_reg)
			wr_data = dmem_rdata;
		else if (ctl.rtrn)
			wr_data = rd1 + 16'd1; // Pop
		else if (ctl.reg_rt_src && ctl.reg_write)
			wr_data = byte_merge;
		else
			wr_data = alu_result; // ALU ops, and SP - 1 on CALL
	end

	assign wr_idx = stack_op ? reg_sp : instr.r.rd;
	assign wr_en  = ctl.reg_write & ~halted;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= 16'h0000;
			regs[reg_sp] <= sp_reset;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Halt latch in pc_unit must freeze the architectural state
	a_frozen_when_halted: assert property (@(posedge clk) disable iff (rst)
		halted |=> $stable(regs[reg_sp]) && $stable(regs[reg_ds]))
		else $error("register write while halted");

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert -f files.f --top-module cpu_tb -o cpu_tb_sim \
	&& ./obj_dir/cpu_tb_sim | grep -x "Finished with no errors" \
	|| exit 1
